// ==== src/clic_pkg.sv ====
/*
 * CLIC shared definitions
 * Privilege and register-map encodings, per-source configuration,
 * candidate interrupt, status and hypervisor control structs.
 */
package clic_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN    = 32;  // Cause width
  localparam int unsigned ID_W    = 16;  // Id field in candidate and cause
  localparam int unsigned LVL_W   = 8;   // Interrupt level
  localparam int unsigned VSID_W  = 6;   // Guest id, indexes hgeie
  localparam int unsigned ADDR_W  = 8;   // APB byte address
  localparam int unsigned APB_DW  = 32;  // APB data

  // Hart privilege, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Register map, word offsets
  typedef enum logic [ADDR_W-3:0] {
    REG_SRC_CFG = 6'd0,  // Config of selected source
    REG_SRC_SEL = 6'd1   // Source index for REG_SRC_CFG
  } clic_reg_e;

  // Per-source configuration, 24 bits, ie in bit 0
  typedef struct packed {
    logic [4:0]        spare;
    logic [VSID_W-1:0] vsid;
    logic              v;          // Delegated to a guest
    priv_lvl_e         priv;
    logic [LVL_W-1:0]  level;
    logic              trig_edge;  // 1 edge, 0 level
    logic              ie;
  } src_cfg_t;

  localparam int unsigned CFG_W = $bits(src_cfg_t);

  // Candidate from arbiter to hart controller
  typedef struct packed {
    logic              valid;
    logic [ID_W-1:0]   id;
    logic [LVL_W-1:0]  level;
    priv_lvl_e         priv;
    logic              v;
    logic [VSID_W-1:0] vsid;
  } clic_irq_t;

  // Interrupt status, mil on top
  typedef struct packed {
    logic [LVL_W-1:0] mil;
    logic [LVL_W-1:0] sil;
    logic [LVL_W-1:0] vsil;
  } intstatus_t;

  // S-mode and hypervisor enables
  typedef struct packed {
    logic              sie;
    logic              sgeie;
    logic [VSID_W-1:0] vgein;  // Running guest
    logic [63:0]       hgeie;
  } irq_ctrl_t;

endpackage

// ==== src/clic_apb_regs.sv ====
/*
 * CLIC configuration registers
 * Zero-wait APB slave, indirect access to per-source config
 * through a source-select register.
 */
`timescale 1ns/1ps

module clic_apb_regs #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // APB slave
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [clic_pkg::ADDR_W-1:0]      paddr_i,
  input  logic [clic_pkg::APB_DW-1:0]      pwdata_i,
  output logic [clic_pkg::APB_DW-1:0]      prdata_o,
  output logic                             pready_o,
  // To gateways and arbiter
  output clic_pkg::src_cfg_t [NumSrc-1:0]  cfg_o
);

  localparam int unsigned SelW = $clog2(NumSrc);

  clic_pkg::clic_reg_e                reg_addr;
  logic                               wr_en;
  logic                               sel_ok;    // Select in range
  logic [SelW-1:0]                    sel_q;
  clic_pkg::src_cfg_t [NumSrc-1:0]    cfg_q;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign reg_addr = clic_pkg::clic_reg_e'(paddr_i[clic_pkg::ADDR_W-1:2]);  // Word offset
  assign wr_en    = psel_i & penable_i & pwrite_i;  // Access phase only
  assign sel_ok   = (pwdata_i < NumSrc);
  assign pready_o = 1'b1;                           // No wait states

  // Source select
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else if (wr_en && (reg_addr == clic_pkg::REG_SRC_SEL) && sel_ok) begin
      sel_q <= pwdata_i[SelW-1:0];  // Out-of-range selects dropped
    end
  end

  // Config array, cleared so every source starts disabled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_en && (reg_addr == clic_pkg::REG_SRC_CFG)) begin
      cfg_q[sel_q] <= clic_pkg::src_cfg_t'(pwdata_i[clic_pkg::CFG_W-1:0]);
    end
  end

  assign cfg_o = cfg_q;

  // --------------------------------------------------
  // Read-back
  // --------------------------------------------------
  // Combinational, valid through setup and access
  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i) begin
      case (reg_addr)
        clic_pkg::REG_SRC_CFG: prdata_o[clic_pkg::CFG_W-1:0] = cfg_q[sel_q];
        clic_pkg::REG_SRC_SEL: prdata_o[SelW-1:0]            = sel_q;
        default:               prdata_o                      = '0;  // Unmapped reads 0
      endcase
    end
  end

endmodule

// ==== src/clic_gateway.sv ====
/*
 * CLIC gateways
 * Per-source pending latches, level or edge triggered,
 * cleared by the arbiter's claim.
 */
`timescale 1ns/1ps

module clic_gateway #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [NumSrc-1:0]               src_i,
  input  clic_pkg::src_cfg_t [NumSrc-1:0] cfg_i,
  input  logic [NumSrc-1:0]               claim_i,    // One-hot, from arbiter
  output logic [NumSrc-1:0]               pending_o
);

  logic [NumSrc-1:0] src_q;      // Previous input, for edge detect
  logic [NumSrc-1:0] src_rise;
  logic [NumSrc-1:0] pending_d;
  logic [NumSrc-1:0] pending_q;

  assign src_rise = src_i & ~src_q;

  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      if (!cfg_i[i].ie) begin
        pending_d[i] = 1'b0;                                  // Disabled, never pending
      end else if (cfg_i[i].trig_edge) begin
        pending_d[i] = src_rise[i] | (pending_q[i] & ~claim_i[i]);  // New edge beats claim
      end else begin
        pending_d[i] = src_i[i] & ~claim_i[i];                // Level, claim masks one cycle
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q     <= '0;
      pending_q <= '0;
    end else begin
      src_q     <= src_i;
      pending_q <= pending_d;
    end
  end

  assign pending_o = pending_q;

endmodule

// ==== src/clic_arbiter.sv ====
/*
 * CLIC arbiter
 * Scans for the highest pending level, lowest id on a tie,
 * holds the offer until ack or kill, requests kill on preemption.
 */
`timescale 1ns/1ps

module clic_arbiter #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [NumSrc-1:0]               pending_i,
  input  clic_pkg::src_cfg_t [NumSrc-1:0] cfg_i,
  input  logic                            ready_i,     // Hart took the interrupt
  input  logic                            kill_ack_i,
  output clic_pkg::clic_irq_t             cand_o,
  output logic [NumSrc-1:0]               claim_o,
  output logic                            kill_req_o
);

  localparam int unsigned IdxW = $clog2(NumSrc);

  logic                         best_found;
  logic [IdxW-1:0]              best_idx;
  logic [clic_pkg::LVL_W-1:0]   best_level;
  clic_pkg::clic_irq_t          best_irq;
  logic                         cand_valid_q;
  clic_pkg::clic_irq_t          cand_q;       // Payload, valid field unused

  // --------------------------------------------------
  // Max-level scan
  // --------------------------------------------------
  always_comb begin
    best_found = 1'b0;
    best_idx   = '0;
    best_level = '0;
    for (int i = 0; i < NumSrc; i++) begin
      // Strict compare keeps lower id on tie
      if (pending_i[i] && cfg_i[i].ie && (!best_found || (cfg_i[i].level > best_level))) begin
        best_found = 1'b1;
        best_idx   = IdxW'(i);
        best_level = cfg_i[i].level;
      end
    end
  end

  always_comb begin
    best_irq.valid = best_found;
    best_irq.id    = clic_pkg::ID_W'(best_idx);
    best_irq.level = best_level;
    best_irq.priv  = cfg_i[best_idx].priv;
    best_irq.v     = cfg_i[best_idx].v;
    best_irq.vsid  = cfg_i[best_idx].vsid;
  end

  // --------------------------------------------------
  // Offer register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cand_valid_q <= 1'b0;
    end else if (cand_valid_q) begin
      if (ready_i || kill_ack_i) begin
        cand_valid_q <= 1'b0;  // One idle cycle before re-offer
      end
    end else begin
      cand_valid_q <= best_found;
    end
  end

  // Load only while idle, held stable otherwise
  always_ff @(posedge clk_i) begin
    if (!cand_valid_q) begin
      cand_q <= best_irq;
    end
  end

  always_comb begin
    cand_o       = cand_q;
    cand_o.valid = cand_valid_q;
  end

  // Claim pulse back to gateway of taken source
  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      claim_o[i] = ready_i & cand_valid_q & (cand_q.id == clic_pkg::ID_W'(i));
    end
  end

  // Preempt only for strictly higher level
  assign kill_req_o = cand_valid_q & best_found & (best_level > cand_q.level);

endmodule

// ==== src/clic_hart_ctrl.sv ====
/*
 * CLIC hart-side controller
 * Filters the candidate on privilege, virtualization and thresholds,
 * packs the trap cause and gates kill against an in-flight interrupt.
 */
`timescale 1ns/1ps

module clic_hart_ctrl #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Hart state
  input  clic_pkg::priv_lvl_e           priv_lvl_i,
  input  logic                          v_i,             // Hart runs virtualized
  input  clic_pkg::irq_ctrl_t           irq_ctrl_i,
  input  logic [clic_pkg::LVL_W-1:0]    mintthresh_i,
  input  logic [clic_pkg::LVL_W-1:0]    sintthresh_i,
  input  logic [clic_pkg::LVL_W-1:0]    vsintthresh_i,
  input  clic_pkg::intstatus_t          mintstatus_i,
  // Arbiter side
  input  clic_pkg::clic_irq_t           cand_i,
  input  logic                          ready_i,         // Hart ack
  input  logic                          kill_req_i,
  output logic                          kill_ack_o,
  // To hart
  output logic                          irq_req_o,
  output clic_pkg::priv_lvl_e           irq_priv_o,
  output logic                          irq_v_o,
  output logic [clic_pkg::XLEN-1:0]     irq_cause_o
);

  localparam int unsigned IdxW = $clog2(NumSrc);

  logic [clic_pkg::LVL_W-1:0] mth;   // Effective thresholds
  logic [clic_pkg::LVL_W-1:0] sth;
  logic [clic_pkg::LVL_W-1:0] vsth;
  logic                       inflight_d;
  logic                       inflight_q;

  function automatic logic [clic_pkg::LVL_W-1:0] lvl_max(
    input logic [clic_pkg::LVL_W-1:0] a,
    input logic [clic_pkg::LVL_W-1:0] b
  );
    return (a > b) ? a : b;
  endfunction

  // --------------------------------------------------
  // Acceptance filter
  // --------------------------------------------------
  // Running level counts as threshold too
  assign mth  = lvl_max(mintthresh_i, mintstatus_i.mil);
  assign sth  = lvl_max(sintthresh_i, mintstatus_i.sil);
  assign vsth = lvl_max(vsintthresh_i, mintstatus_i.vsil);

  always_comb begin
    irq_priv_o = cand_i.priv;
    irq_v_o    = 1'b0;
    irq_req_o  = 1'b0;
    case (priv_lvl_i)
      clic_pkg::PRIV_M: begin
        if (cand_i.priv == clic_pkg::PRIV_M) begin
          irq_req_o = cand_i.valid && (cand_i.level > mth);
        end
      end
      clic_pkg::PRIV_S: begin
        if (cand_i.priv == clic_pkg::PRIV_M) begin
          irq_req_o = cand_i.valid;                        // M always above S
        end else if (cand_i.priv == clic_pkg::PRIV_S) begin
          if (!v_i) begin
            // HS-mode, guest interrupts left waiting
            if (!cand_i.v) begin
              irq_req_o = cand_i.valid && (cand_i.level > sth) && irq_ctrl_i.sie;
            end
          end else if (!cand_i.v) begin
            irq_req_o = cand_i.valid && (cand_i.level > sth);  // Host S, sie implied
          end else if (cand_i.vsid == irq_ctrl_i.vgein) begin
            // For the running guest
            irq_req_o = cand_i.valid && (cand_i.level > vsth) && irq_ctrl_i.sie;
            irq_v_o   = 1'b1;
          end else begin
            // Other guest, route to hypervisor
            irq_req_o = cand_i.valid && irq_ctrl_i.sgeie && irq_ctrl_i.hgeie[cand_i.vsid];
          end
        end
      end
      clic_pkg::PRIV_U: begin
        irq_req_o = cand_i.valid;
        irq_v_o   = cand_i.v;
      end
      default: irq_req_o = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Cause packer
  // --------------------------------------------------
  assign irq_cause_o = {1'b1,                                                    // Interrupt
                        {(clic_pkg::XLEN - 1 - clic_pkg::LVL_W - clic_pkg::ID_W){1'b0}},
                        cand_i.level,                                            // Bits 23:16
                        {(clic_pkg::ID_W - IdxW){1'b0}},
                        cand_i.id[IdxW-1:0]};

  // --------------------------------------------------
  // Kill control
  // --------------------------------------------------
  // Set on request, held until ack or kill
  assign inflight_d = inflight_q ? ~(ready_i | kill_ack_o) : irq_req_o;
  assign kill_ack_o = kill_req_i & ~inflight_q & ~irq_req_o;  // Safe only when idle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// ==== src/clic_top.sv ====
/*
 * CLIC subsystem top
 * APB config registers, gateways and arbiter feeding the
 * hart-side controller of one hypervisor-capable hart.
 */
`timescale 1ns/1ps

module clic_top #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // APB
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [clic_pkg::ADDR_W-1:0]   paddr_i,
  input  logic [clic_pkg::APB_DW-1:0]   pwdata_i,
  output logic [clic_pkg::APB_DW-1:0]   prdata_o,
  output logic                          pready_o,
  // Interrupt sources
  input  logic [NumSrc-1:0]             src_i,
  // Hart state, from CSR file
  input  clic_pkg::priv_lvl_e           priv_lvl_i,
  input  logic                          v_i,
  input  clic_pkg::irq_ctrl_t           irq_ctrl_i,
  input  logic [clic_pkg::LVL_W-1:0]    mintthresh_i,
  input  logic [clic_pkg::LVL_W-1:0]    sintthresh_i,
  input  logic [clic_pkg::LVL_W-1:0]    vsintthresh_i,
  input  clic_pkg::intstatus_t          mintstatus_i,
  // Hart side
  output logic                          irq_req_o,
  output clic_pkg::priv_lvl_e           irq_priv_o,
  output logic                          irq_v_o,
  output logic [clic_pkg::XLEN-1:0]     irq_cause_o,
  input  logic                          irq_ack_i
);

  clic_pkg::src_cfg_t [NumSrc-1:0] cfg;
  logic [NumSrc-1:0]               pending;
  logic [NumSrc-1:0]               claim;
  clic_pkg::clic_irq_t             cand;
  logic                            kill_req;
  logic                            kill_ack;

  clic_apb_regs #(.NumSrc(NumSrc)) regs_i (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o,
    .cfg_o      (cfg)
  );

  clic_gateway #(.NumSrc(NumSrc)) gw_i (
    .clk_i, .rst_ni,
    .src_i,
    .cfg_i      (cfg),
    .claim_i    (claim),
    .pending_o  (pending)
  );

  clic_arbiter #(.NumSrc(NumSrc)) arb_i (
    .clk_i, .rst_ni,
    .pending_i  (pending),
    .cfg_i      (cfg),
    .ready_i    (irq_ack_i),   // Ack claims the offer
    .kill_ack_i (kill_ack),
    .cand_o     (cand),
    .claim_o    (claim),
    .kill_req_o (kill_req)
  );

  clic_hart_ctrl #(.NumSrc(NumSrc)) ctrl_i (
    .clk_i, .rst_ni,
    .priv_lvl_i, .v_i, .irq_ctrl_i,
    .mintthresh_i, .sintthresh_i, .vsintthresh_i, .mintstatus_i,
    .cand_i     (cand),
    .ready_i    (irq_ack_i),
    .kill_req_i (kill_req),
    .kill_ack_o (kill_ack),
    .irq_req_o, .irq_priv_o, .irq_v_o, .irq_cause_o
  );

endmodule

// ==== sim/clic_checker.sv ====
/*
 * CLIC port checker
 * Recomputes the hart acceptance rule and the cause format
 * from the top ports, plus offer hold and ack behavior.
 */
`timescale 1ns/1ps

module clic_checker #(
  parameter int unsigned NumSrc = 8
) (
  input logic                          clk_i,
  input logic                          rst_ni,
  input clic_pkg::priv_lvl_e           priv_lvl_i,
  input logic                          v_i,
  input clic_pkg::irq_ctrl_t           irq_ctrl_i,
  input logic [7:0]                    mintthresh_i,
  input logic [7:0]                    sintthresh_i,
  input logic [7:0]                    vsintthresh_i,
  input clic_pkg::intstatus_t          mintstatus_i,
  input logic                          irq_req_o,
  input clic_pkg::priv_lvl_e           irq_priv_o,
  input logic                          irq_v_o,
  input logic [clic_pkg::XLEN-1:0]     irq_cause_o,
  input logic                          irq_ack_i,
  input clic_pkg::clic_irq_t           cand_i      // Offered candidate, internal
);

  localparam int unsigned IdxW = $clog2(NumSrc);

  int unsigned fail_cnt = 0;   // Failed assertions so far
  logic [7:0]  lvl;
  logic [7:0]  m_th;
  logic [7:0]  s_th;
  logic [7:0]  vs_th;
  logic        exp_req;
  logic        exp_v;

  assign lvl   = irq_cause_o[23:16];  // Level as packed in cause
  assign m_th  = (mintthresh_i > mintstatus_i.mil) ? mintthresh_i : mintstatus_i.mil;
  assign s_th  = (sintthresh_i > mintstatus_i.sil) ? sintthresh_i : mintstatus_i.sil;
  assign vs_th = (vsintthresh_i > mintstatus_i.vsil) ? vsintthresh_i : mintstatus_i.vsil;

  // --------------------------------------------------
  // Expected request and virtual bit
  // --------------------------------------------------
  always_comb begin
    exp_req = 1'b0;
    exp_v   = 1'b0;
    if (priv_lvl_i == clic_pkg::PRIV_M) begin
      exp_req = (irq_priv_o == clic_pkg::PRIV_M) && (lvl > m_th);
    end else if (priv_lvl_i == clic_pkg::PRIV_U) begin
      exp_req = 1'b1;                                     // Anything preempts U
      exp_v   = cand_i.v;
    end else if (priv_lvl_i == clic_pkg::PRIV_S) begin
      if (irq_priv_o == clic_pkg::PRIV_M) begin
        exp_req = 1'b1;
      end else if ((irq_priv_o == clic_pkg::PRIV_S) && !cand_i.v) begin
        exp_req = (lvl > s_th) && (irq_ctrl_i.sie || v_i);  // sie implied under V
      end else if ((irq_priv_o == clic_pkg::PRIV_S) && v_i) begin
        if (cand_i.vsid == irq_ctrl_i.vgein) begin
          exp_req = (lvl > vs_th) && irq_ctrl_i.sie;
          exp_v   = 1'b1;
        end else begin
          exp_req = irq_ctrl_i.sgeie && irq_ctrl_i.hgeie[cand_i.vsid];
        end
      end
    end
    exp_req = exp_req && cand_i.valid;
  end

  a_req_rule : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_o == exp_req)
    else begin fail_cnt++; $error("irq_req_o breaks acceptance rule"); end

  a_v_rule : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_v_o == exp_v)
    else begin fail_cnt++; $error("irq_v_o breaks virtualization rule"); end

  a_cause_fmt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_o |-> irq_cause_o[31] && (irq_cause_o[30:24] == '0) && (irq_cause_o[15:IdxW] == '0))
    else begin fail_cnt++; $error("cause has bad fixed bits"); end

  a_cause_fields : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cand_i.valid |-> (lvl == cand_i.level) && (irq_cause_o[IdxW-1:0] == cand_i.id[IdxW-1:0]))
    else begin fail_cnt++; $error("cause level or id field wrong"); end

  // Requested offer is frozen until the hart acks
  a_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_o && !irq_ack_i |=> $stable(irq_cause_o) && $stable(irq_priv_o))
    else begin fail_cnt++; $error("requested cause changed before ack"); end

  a_ack_drop : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_o && irq_ack_i |=> !irq_req_o)
    else begin fail_cnt++; $error("request still high the cycle after ack"); end

endmodule

// ==== sim/clic_tb.sv ====
/*
 * CLIC subsystem testbench
 * APB config and read-back, M, S, VS and U hart states,
 * arbitration order, preemption and offer hold.
 */
`timescale 1ns/1ps

module clic_tb;

  localparam int unsigned NumSrc        = 8;
  localparam int unsigned NumRounds     = 12;
  localparam int unsigned TimeoutCycles = 50 * (NumSrc + 3 * NumRounds) + 500;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        psel_i;
  logic                        penable_i;
  logic                        pwrite_i;
  logic [7:0]                  paddr_i;
  logic [31:0]                 pwdata_i;
  logic [31:0]                 prdata_o;
  logic                        pready_o;
  logic [NumSrc-1:0]           src_i;
  clic_pkg::priv_lvl_e         priv_lvl_i;
  logic                        v_i;
  clic_pkg::irq_ctrl_t         irq_ctrl_i;
  logic [7:0]                  mintthresh_i;
  logic [7:0]                  sintthresh_i;
  logic [7:0]                  vsintthresh_i;
  clic_pkg::intstatus_t        mintstatus_i;
  logic                        irq_req_o;
  clic_pkg::priv_lvl_e         irq_priv_o;
  logic                        irq_v_o;
  logic [31:0]                 irq_cause_o;
  logic                        irq_ack_i;

  clic_top #(.NumSrc(NumSrc)) dut_i (.*);

  bind clic_top clic_checker #(.NumSrc(NumSrc)) chk_i (
    .clk_i, .rst_ni, .priv_lvl_i, .v_i, .irq_ctrl_i,
    .mintthresh_i, .sintthresh_i, .vsintthresh_i, .mintstatus_i,
    .irq_req_o, .irq_priv_o, .irq_v_o, .irq_cause_o, .irq_ack_i,
    .cand_i (cand)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      fail_run($sformatf("error @ %0d ns: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic clic_pkg::src_cfg_t make_cfg(input logic [7:0] level,
      input clic_pkg::priv_lvl_e priv, input logic v, input logic [5:0] vsid);
    clic_pkg::src_cfg_t c;
    c           = '0;
    c.ie        = 1'b1;
    c.trig_edge = 1'b1;   // All stimulus sources are edge triggered
    c.level     = level;
    c.priv      = priv;
    c.v         = v;
    c.vsid      = vsid;
    return c;
  endfunction

  // Interrupt flag, zeros, level in 23:16, id below
  function automatic logic [31:0] cause_of(input logic [7:0] level, input int unsigned id);
    return {1'b1, 7'd0, level, 16'(id)};
  endfunction

  task automatic apb_write(input clic_pkg::clic_reg_e reg_addr, input logic [31:0] data);
    @(posedge clk_i);
    psel_i    <= 1'b1;   // Setup
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= {reg_addr, 2'b00};
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;   // Access
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_read(input clic_pkg::clic_reg_e reg_addr, output logic [31:0] data);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= {reg_addr, 2'b00};
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    data = prdata_o;     // Mid access phase
    check_eq(pready_o, 1'b1, "pready_o in access phase");
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic set_source(input int unsigned idx, input clic_pkg::src_cfg_t cfg);
    apb_write(clic_pkg::REG_SRC_SEL, 32'(idx));
    apb_write(clic_pkg::REG_SRC_CFG, 32'(cfg));
  endtask

  // One-cycle high pulse, returns on the edge that latches pending
  task automatic pulse_src(input int unsigned idx);
    @(posedge clk_i);
    src_i[idx] <= 1'b1;
    @(posedge clk_i);
    src_i[idx] <= 1'b0;
  endtask

  task automatic wait_req();
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!irq_req_o && (n < 50));
    if (!irq_req_o) begin
      fail_run("no interrupt request within 50 cycles");
    end
  endtask

  task automatic ack_irq();
    @(posedge clk_i);
    irq_ack_i <= 1'b1;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
  endtask

  task automatic random_hart_state();
    @(posedge clk_i);
    priv_lvl_i       <= ($urandom % 4 == 0) ? clic_pkg::PRIV_U : clic_pkg::PRIV_S;
    v_i              <= 1'($urandom);
    irq_ctrl_i.sie   <= 1'($urandom);
    irq_ctrl_i.sgeie <= 1'($urandom);
    irq_ctrl_i.vgein <= 6'(3 + 2 * ($urandom % 3));  // Guest 3, 5 or 7
    irq_ctrl_i.hgeie <= {$urandom, $urandom};
    sintthresh_i     <= 8'($urandom % 128);
    vsintthresh_i    <= 8'($urandom % 128);
    mintstatus_i     <= {8'd0, 8'($urandom % 128), 8'($urandom % 128)};
  endtask

  // Stop at the first bound assertion failure
  always @(negedge clk_i) begin
    if (dut_i.chk_i.fail_cnt != 0) begin
      fail_run("bound checker reported an assertion failure");
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    fail_run("watchdog expired before the tests finished");
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0]         rd;
    logic [7:0]          lvl;
    logic [7:0]          th;
    logic [7:0]          mil;
    int unsigned         src_idx;
    clic_pkg::priv_lvl_e exp_priv;
    clic_pkg::src_cfg_t  cfg_wr [NumSrc];
    void'($urandom(32'h3418));
    rst_ni        = 1'b0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    paddr_i       = '0;
    pwdata_i      = '0;
    src_i         = '0;
    priv_lvl_i    = clic_pkg::PRIV_M;
    v_i           = 1'b0;
    irq_ctrl_i    = '0;
    mintthresh_i  = '0;
    sintthresh_i  = '0;
    vsintthresh_i = '0;
    mintstatus_i  = '0;
    irq_ack_i     = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Unconfigured sources stay silent
    @(posedge clk_i);
    src_i <= '1;
    repeat (10) begin
      @(negedge clk_i);
      check_eq(irq_req_o, 1'b0, "request from disabled source");
    end
    @(posedge clk_i);
    src_i <= '0;

    // Read-back, ie kept low
    for (int i = 0; i < NumSrc; i++) begin
      cfg_wr[i] = clic_pkg::src_cfg_t'($urandom & 32'h00ff_fffe);
      set_source(i, cfg_wr[i]);
    end
    for (int i = 0; i < NumSrc; i++) begin
      apb_write(clic_pkg::REG_SRC_SEL, 32'(i));
      apb_read(clic_pkg::REG_SRC_CFG, rd);
      check_eq(rd, 32'(cfg_wr[i]), "config read-back");
    end
    apb_write(clic_pkg::REG_SRC_SEL, 32'(NumSrc + 1));  // Out of range, dropped
    apb_read(clic_pkg::REG_SRC_SEL, rd);
    check_eq(rd, NumSrc - 1, "select after out-of-range write");

    // M-mode threshold against mil
    for (int r = 0; r < NumRounds; r++) begin
      lvl = 8'(1 + $urandom % 255);
      th  = 8'($urandom);
      mil = 8'($urandom);
      set_source(0, make_cfg(lvl, clic_pkg::PRIV_M, 1'b0, 6'd0));
      @(posedge clk_i);
      mintthresh_i <= th;
      mintstatus_i <= {mil, 16'd0};
      pulse_src(0);
      @(negedge clk_i);
      check_eq(irq_req_o, 1'b0, "request before offer registered");
      @(posedge clk_i);
      @(negedge clk_i);
      check_eq(irq_req_o, (lvl > th) && (lvl > mil), "M-mode request two cycles after edge");
      @(posedge clk_i);
      mintthresh_i <= '0;   // Release a held offer
      mintstatus_i <= '0;
      wait_req();
      ack_irq();
    end

    // S, VS and U hart states, rule checked by the bound checker
    set_source(1, make_cfg(8'h40, clic_pkg::PRIV_S, 1'b0, 6'd0));
    set_source(2, make_cfg(8'h50, clic_pkg::PRIV_S, 1'b1, 6'd3));
    set_source(3, make_cfg(8'h60, clic_pkg::PRIV_S, 1'b1, 6'd5));
    for (int r = 0; r < NumRounds; r++) begin
      random_hart_state();
      src_idx = $urandom % 4;
      pulse_src(src_idx);
      repeat (3) @(posedge clk_i);
      random_hart_state();
      repeat (3) @(posedge clk_i);
      priv_lvl_i <= clic_pkg::PRIV_U;  // Takes anything
      wait_req();
      exp_priv = (src_idx == 0) ? clic_pkg::PRIV_M : clic_pkg::PRIV_S;  // Source 0 is M
      check_eq(32'(irq_priv_o), 32'(exp_priv), "privilege of pulsed source");
      ack_irq();
    end

    // Arbitration order
    set_source(4, make_cfg(8'h90, clic_pkg::PRIV_M, 1'b0, 6'd0));
    set_source(5, make_cfg(8'h90, clic_pkg::PRIV_M, 1'b0, 6'd0));
    set_source(6, make_cfg(8'h70, clic_pkg::PRIV_M, 1'b0, 6'd0));
    set_source(7, make_cfg(8'hc0, clic_pkg::PRIV_M, 1'b0, 6'd0));
    @(posedge clk_i);
    priv_lvl_i   <= clic_pkg::PRIV_M;
    v_i          <= 1'b0;
    mintstatus_i <= '0;
    @(posedge clk_i);
    src_i[6:4] <= 3'b111;
    wait_req();
    check_eq(irq_cause_o, cause_of(8'h90, 4), "tie goes to lowest id");
    ack_irq();
    wait_req();
    check_eq(irq_cause_o, cause_of(8'h90, 5), "second of equal levels");
    ack_irq();
    wait_req();
    check_eq(irq_cause_o, cause_of(8'h70, 6), "lowest level last");
    ack_irq();
    repeat (4) begin
      @(negedge clk_i);
      check_eq(irq_req_o, 1'b0, "claimed edge source offered again");
    end
    @(posedge clk_i);
    src_i[6:4] <= '0;

    // Preemption of an unrequested offer
    @(posedge clk_i);
    mintthresh_i <= 8'ha0;
    pulse_src(6);
    repeat (3) begin
      @(negedge clk_i);
      check_eq(irq_req_o, 1'b0, "level below threshold requested");
    end
    pulse_src(7);
    wait_req();
    check_eq(irq_cause_o, cause_of(8'hc0, 7), "higher source replaces held offer");
    ack_irq();
    @(posedge clk_i);
    mintthresh_i <= '0;
    wait_req();
    check_eq(irq_cause_o, cause_of(8'h70, 6), "preempted source offered again");
    ack_irq();

    // Requested offer holds until ack
    pulse_src(6);
    wait_req();
    pulse_src(7);
    repeat (4) begin
      @(negedge clk_i);
      check_eq(irq_cause_o, cause_of(8'h70, 6), "requested cause replaced before ack");
    end
    ack_irq();
    wait_req();
    check_eq(irq_cause_o, cause_of(8'hc0, 7), "waiting source after ack");
    ack_irq();

    repeat (5) @(posedge clk_i);
    if (dut_i.chk_i.fail_cnt != 0) begin
      fail_run("bound checker reported an assertion failure");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
src/clic_pkg.sv
src/clic_apb_regs.sv
src/clic_gateway.sv
src/clic_arbiter.sv
src/clic_hart_ctrl.sv
src/clic_top.sv
sim/clic_checker.sv
sim/clic_tb.sv
